/* hw/oflow_bbox_pkg.sv */
/*
 * Optical-flow box store channel types
 * Box payload and the frame, write, read and response channel structs
 */
package oflow_bbox_pkg;

	typedef struct packed {
		logic [oflow_cfg_pkg::COORD_WIDTH-1:0] x; // Top-left corner
		logic [oflow_cfg_pkg::COORD_WIDTH-1:0] y;
		logic [oflow_cfg_pkg::COORD_WIDTH-1:0] w; // Width and height
		logic [oflow_cfg_pkg::COORD_WIDTH-1:0] h;
	} bbox_t;

	typedef struct packed {
		logic [oflow_cfg_pkg::FRAME_NUM_WIDTH-1:0] frame_num; // Serial number of the new frame
		logic [oflow_cfg_pkg::HIST_WIDTH-1:0] num_hist; // Requested N, clamped to 1..5
	} frame_cfg_t;

	typedef struct packed {
		logic [oflow_cfg_pkg::ADDR_WIDTH-1:0] offset_0; // Offsets inside the current region
		logic [oflow_cfg_pkg::ADDR_WIDTH-1:0] offset_1;
		bbox_t bbox_0; // Goes to port 0
		bbox_t bbox_1; // Goes to port 1
	} wr_req_t;

	typedef struct packed {
		logic [oflow_cfg_pkg::HIST_WIDTH-1:0] frames_back; // 1 is the previous frame
		logic [oflow_cfg_pkg::ADDR_WIDTH-1:0] offset_0;
		logic [oflow_cfg_pkg::ADDR_WIDTH-1:0] offset_1;
	} rd_req_t;

	typedef struct packed {
		bbox_t bbox_0;
		bbox_t bbox_1;
		logic err; // Out of range request, boxes are zero
	} rd_rsp_t;

endpackage

/* hw/oflow_bbox_ram.sv */
/*
 * Dual-port box RAM
 * Two synchronous ports with registered read, port 1 wins on a write clash
 */
`timescale 1ns/1ns

module oflow_bbox_ram import oflow_cfg_pkg::*; import oflow_bbox_pkg::*; (
	input logic clk,
	input logic [ADDR_WIDTH-1:0] addr_0,
	input logic [ADDR_WIDTH-1:0] addr_1,
	input logic we_0,
	input logic we_1,
	input bbox_t wdata_0,
	input bbox_t wdata_1,
	output bbox_t rdata_0, // Valid the cycle after the address
	output bbox_t rdata_1
);

	bbox_t mem [MEM_DEPTH]; // All history regions share this array

	// One process for both ports so the later write takes the clash
	always_ff @(posedge clk) begin
		if (we_0)
			mem[addr_0] <= wdata_0;
		if (we_1)
			mem[addr_1] <= wdata_1; // Overrides port 0 on the same address
		rdata_0 <= mem[addr_0]; // Read before write, old data on a write
		rdata_1 <= mem[addr_1];
	end

endmodule

/* hw/oflow_cfg_pkg.sv */
/*
 * Optical-flow box store configuration
 * Memory geometry, history limits and field widths
 */
package oflow_cfg_pkg;

	// Box RAM geometry
	localparam int MEM_DEPTH = 128; // Total entries shared by all history regions
	localparam int ADDR_WIDTH = $clog2(MEM_DEPTH); // Also the width of a region offset

	// History frames
	localparam int MAX_HISTORY = 5; // Largest N, smallest region is 25 entries
	localparam int HIST_WIDTH = 3; // Holds N and frames_back
	localparam int FRAME_NUM_WIDTH = 8; // Frame serial number, wraps at 256

	// Box fields
	localparam int COORD_WIDTH = 8; // Each of x, y, w, h

	// Response buffer
	localparam int RSP_FIFO_DEPTH = 2; // Enough for one stalled response plus one in flight
	localparam int RSP_PTR_WIDTH = $clog2(RSP_FIFO_DEPTH);
	localparam int RSP_CNT_WIDTH = $clog2(RSP_FIFO_DEPTH + 1); // Counts 0 up to full

endpackage

/* hw/oflow_mem_buffer.sv */
/*
 * Box memory buffer
 * Maps write and read requests onto the RAM ports, checks ranges
 * and queues read responses in order under back-pressure
 */
`timescale 1ns/1ns

module oflow_mem_buffer import oflow_cfg_pkg::*; import oflow_bbox_pkg::*; (
	input logic clk,
	input logic reset_N,
	input logic wr_valid,
	output logic wr_ready,
	input wr_req_t wr,
	output logic wr_drop, // Pulses the cycle after an out of range write
	input logic rd_valid,
	output logic rd_ready,
	input rd_req_t rd,
	output logic rsp_valid,
	input logic rsp_ready,
	output rd_rsp_t rsp,
	output logic [HIST_WIDTH-1:0] frames_back,
	input logic loaded,
	input logic [ADDR_WIDTH-1:0] region_size,
	input logic [ADDR_WIDTH-1:0] wr_base,
	input logic [ADDR_WIDTH-1:0] rd_base,
	input logic rd_slot_ok
);

	logic wr_fire, rd_fire, wr_in_range, rd_err;
	logic ram_we;
	logic [ADDR_WIDTH-1:0] addr_0, addr_1;
	bbox_t rdata_0, rdata_1;
	logic inflight_q; // RAM is returning a read this cycle
	logic err_q;
	rd_rsp_t rsp_mem [RSP_FIFO_DEPTH];
	rd_rsp_t push_data;
	logic [RSP_PTR_WIDTH-1:0] wr_ptr, rd_ptr;
	logic [RSP_CNT_WIDTH-1:0] rsp_count;
	logic [RSP_CNT_WIDTH:0] rsp_used; // Buffered plus in flight
	logic push, pop;

	// Size zero means N = 1 where any offset fits
	function automatic logic offset_ok(input logic [ADDR_WIDTH-1:0] off,
			input logic [ADDR_WIDTH-1:0] size);
		return (size == '0) || (off < size);
	endfunction

	assign frames_back = rd.frames_back;
	assign wr_in_range = offset_ok(wr.offset_0, region_size) && offset_ok(wr.offset_1, region_size);
	assign rd_err = !rd_slot_ok || !offset_ok(rd.offset_0, region_size)
		|| !offset_ok(rd.offset_1, region_size);

	assign rsp_used = rsp_count + inflight_q;
	assign wr_ready = loaded; // Writes never wait once configured
	assign rd_ready = loaded && !wr_valid && (rsp_used < (RSP_CNT_WIDTH+1)'(RSP_FIFO_DEPTH));
	assign wr_fire = wr_valid && wr_ready;
	assign rd_fire = rd_valid && rd_ready;
	assign ram_we = wr_fire && wr_in_range; // Whole write dropped if either offset is bad

	// Write side owns the ports while wr_valid is high
	assign addr_0 = wr_valid ? wr_base + wr.offset_0 : rd_base + rd.offset_0;
	assign addr_1 = wr_valid ? wr_base + wr.offset_1 : rd_base + rd.offset_1;

	oflow_bbox_ram ram_i (
		.clk(clk),
		.addr_0(addr_0),
		.addr_1(addr_1),
		.we_0(ram_we),
		.we_1(ram_we),
		.wdata_0(wr.bbox_0),
		.wdata_1(wr.bbox_1),
		.rdata_0(rdata_0),
		.rdata_1(rdata_1)
	);

	always_comb begin
		push_data = '0; // Error response carries zero boxes
		push_data.err = err_q;
		if (!err_q) begin
			push_data.bbox_0 = rdata_0;
			push_data.bbox_1 = rdata_1;
		end
	end

	assign push = inflight_q; // Room was reserved at acceptance
	assign pop = rsp_valid && rsp_ready;
	assign rsp_valid = rsp_count != '0;
	assign rsp = rsp_mem[rd_ptr]; // Holds while stalled

	always_ff @(posedge clk) begin
		if (push)
			rsp_mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (!reset_N) begin
			inflight_q <= 1'b0;
			err_q <= 1'b0;
			wr_drop <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			rsp_count <= '0;
		end else begin
			inflight_q <= rd_fire;
			err_q <= rd_err;
			wr_drop <= wr_fire && !wr_in_range;
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: rsp_count <= rsp_count + 1'b1;
				2'b01: rsp_count <= rsp_count - 1'b1;
				default: rsp_count <= rsp_count;
			endcase
		end
	end

endmodule

/* hw/oflow_region_map.sv */
/*
 * Region map for the box store
 * Holds the frame configuration and gives region bases and size
 */
`timescale 1ns/1ns

module oflow_region_map import oflow_cfg_pkg::*; import oflow_bbox_pkg::*; (
	input logic clk,
	input logic reset_N,
	input logic frame_valid,
	output logic frame_ready,
	input frame_cfg_t frame,
	input logic [HIST_WIDTH-1:0] frames_back, // From the pending read request
	output logic loaded, // A frame has been seen since reset
	output logic [ADDR_WIDTH-1:0] region_size, // Zero stands for the whole memory (N = 1)
	output logic [ADDR_WIDTH-1:0] wr_base,
	output logic [ADDR_WIDTH-1:0] rd_base,
	output logic rd_slot_ok
);

	logic frame_fire;
	logic [HIST_WIDTH-1:0] n_clamped; // N after clamping the request
	logic [HIST_WIDTH-1:0] num_hist_q;
	logic [HIST_WIDTH-1:0] slot_q; // Region of the current frame
	logic [HIST_WIDTH-1:0] rd_slot;

	assign frame_fire = frame_valid && frame_ready;

	always_comb begin
		if (frame.num_hist == '0)
			n_clamped = HIST_WIDTH'(1); // 0 behaves as a single region
		else if (frame.num_hist > HIST_WIDTH'(MAX_HISTORY))
			n_clamped = HIST_WIDTH'(MAX_HISTORY);
		else
			n_clamped = frame.num_hist;
	end

	always_ff @(posedge clk) begin
		if (!reset_N) begin
			frame_ready <= 1'b0; // High from the first cycle after reset
			loaded <= 1'b0;
			num_hist_q <= HIST_WIDTH'(1);
			region_size <= '0;
			slot_q <= '0;
		end else begin
			frame_ready <= 1'b1;
			if (frame_fire) begin
				loaded <= 1'b1;
				num_hist_q <= n_clamped;
				region_size <= ADDR_WIDTH'(MEM_DEPTH / n_clamped); // 128 wraps to 0
				slot_q <= HIST_WIDTH'(frame.frame_num % FRAME_NUM_WIDTH'(n_clamped)); // f mod N
			end
		end
	end

	// Step back frames_back regions, wrapping inside N
	always_comb begin
		if (frames_back <= slot_q)
			rd_slot = slot_q - frames_back;
		else
			rd_slot = slot_q + num_hist_q - frames_back; // Only meaningful when rd_slot_ok
	end

	assign wr_base = ADDR_WIDTH'(slot_q) * region_size;
	assign rd_base = ADDR_WIDTH'(rd_slot) * region_size;
	assign rd_slot_ok = frames_back < num_hist_q; // Region still holds that frame

endmodule

/* hw/oflow_top.sv */
/*
 * Optical-flow history box store
 * Region map plus memory buffer behind valid/ready channels
 */
`timescale 1ns/1ns

module oflow_top import oflow_cfg_pkg::*; import oflow_bbox_pkg::*; (
	input logic clk,
	input logic reset_N,
	input logic frame_valid, // Frame channel
	output logic frame_ready,
	input frame_cfg_t frame,
	input logic wr_valid, // Write channel
	output logic wr_ready,
	input wr_req_t wr,
	output logic wr_drop,
	input logic rd_valid, // Read channel
	output logic rd_ready,
	input rd_req_t rd,
	output logic rsp_valid, // Response channel
	input logic rsp_ready,
	output rd_rsp_t rsp
);

	logic loaded;
	logic [ADDR_WIDTH-1:0] region_size, wr_base, rd_base;
	logic [HIST_WIDTH-1:0] frames_back; // Read request back to the map
	logic rd_slot_ok;

	oflow_region_map map_i (
		.clk(clk), .reset_N(reset_N),
		.frame_valid(frame_valid), .frame_ready(frame_ready), .frame(frame),
		.frames_back(frames_back), .loaded(loaded), .region_size(region_size),
		.wr_base(wr_base), .rd_base(rd_base), .rd_slot_ok(rd_slot_ok)
	);

	oflow_mem_buffer buf_i (
		.clk(clk), .reset_N(reset_N),
		.wr_valid(wr_valid), .wr_ready(wr_ready), .wr(wr), .wr_drop(wr_drop),
		.rd_valid(rd_valid), .rd_ready(rd_ready), .rd(rd),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
		.frames_back(frames_back), .loaded(loaded), .region_size(region_size),
		.wr_base(wr_base), .rd_base(rd_base), .rd_slot_ok(rd_slot_ok)
	);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the box store testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module oflow_tb \
	-f tb.f --Mdir "$build_dir" -o oflow_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/oflow_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Done: no errors" "$log_file"; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

/* tb.f */
hw/oflow_cfg_pkg.sv
hw/oflow_bbox_pkg.sv
hw/oflow_region_map.sv
hw/oflow_bbox_ram.sv
hw/oflow_mem_buffer.sv
hw/oflow_top.sv
tests/oflow_mem_buffer_assert.sv
tests/oflow_tb.sv

/* tests/oflow_cases.txt */
# F frame_num num_hist | W off_0 off_1 box_0 box_1 | R back off_0 off_1 exp_box_0 exp_box_1 exp_err
# Numbers are decimal except boxes, which are hex x y w h from the top byte down
F 0 4
W 0 1 0a010203 0a040506
F 1 4
W 0 1 0b010203 0b040506
F 2 4
W 0 1 0c010203 0c040506
F 3 4
W 0 1 0d010203 0d040506
F 4 4
R 1 0 1 0d010203 0d040506 0
R 2 0 1 0c010203 0c040506 0
R 3 0 1 0b010203 0b040506 0
R 3 1 0 0b040506 0b010203 0
R 0 0 1 0a010203 0a040506 0
R 4 0 1 00000000 00000000 1
R 1 32 0 00000000 00000000 1
W 0 1 0e010203 0e040506
R 0 0 1 0e010203 0e040506 0
F 9 3
W 10 11 1a101112 1a131415
F 10 3
W 10 11 1b101112 1b131415
F 11 3
W 10 11 1c101112 1c131415
W 41 0 1d101112 1d131415
F 12 3
W 42 0 ee000001 ee000002
R 0 0 1 0e010203 0e040506 0
R 1 10 11 1c101112 1c131415 0
R 2 10 11 1b101112 1b131415 0
R 1 41 0 1d101112 1d131415 0
R 3 10 11 00000000 00000000 1
R 2 42 0 00000000 00000000 1
F 20 5
W 2 3 2a202122 2a232425
W 30 3 dead0001 dead0002
F 21 5
R 1 2 3 2a202122 2a232425 0
R 4 14 15 0c010203 0c040506 0
R 0 7 8 0b010203 0b040506 0
R 5 2 3 00000000 00000000 1
R 1 30 2 00000000 00000000 1
R 1 2 30 00000000 00000000 1
F 30 7
R 0 2 3 2a202122 2a232425 0
F 31 0
W 127 126 3a303132 3a333435
W 100 100 4a404142 4a434445
R 0 127 126 3a303132 3a333435 0
R 0 100 100 4a434445 4a434445 0
R 0 64 65 0c010203 0c040506 0
R 1 0 0 00000000 00000000 1

/* tests/oflow_mem_buffer_assert.sv */
/*
 * Handshake checks for the box memory buffer
 * Response hold under stall, write priority and idle before the first frame
 */
`timescale 1ns/1ns

module oflow_mem_buffer_assert import oflow_bbox_pkg::*; (
	input logic clk,
	input logic reset_N,
	input logic loaded,
	input logic wr_valid,
	input logic wr_ready,
	input logic rd_ready,
	input logic rsp_valid,
	input logic rsp_ready,
	input rd_rsp_t rsp
);

	// Stalled response stays valid and unchanged
	rsp_hold: assert property (@(posedge clk) disable iff (!reset_N)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else $error("Response changed or vanished while stalled");

	wr_prio: assert property (@(posedge clk) disable iff (!reset_N)
		!(rd_ready && wr_valid)) // Writes own both RAM ports
		else $error("rd_ready high while a write is offered");

	idle_unloaded: assert property (@(posedge clk) disable iff (!reset_N)
		!loaded |-> !wr_ready && !rd_ready && !rsp_valid)
		else $error("Channel active before the first frame");

endmodule

bind oflow_mem_buffer oflow_mem_buffer_assert buf_assert_i (
	.clk(clk), .reset_N(reset_N), .loaded(loaded),
	.wr_valid(wr_valid), .wr_ready(wr_ready), .rd_ready(rd_ready),
	.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
);

/* tests/oflow_tb.sv */
/*
 * Testbench for the optical-flow history box store
 * Replays the case file on the frame, write and read channels
 * and checks every response in order under random back-pressure
 */
`timescale 1ns/1ns

module oflow_tb import oflow_cfg_pkg::*; import oflow_bbox_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int DRIVE_DELAY = 1; // Inputs change this long after the rising edge
	localparam int RESET_CYCLES = 5;
	localparam int MAX_CASES = 128;
	localparam string CASE_FILE = "tests/oflow_cases.txt";

	typedef struct packed {
		logic [7:0] kind; // F, W or R
		logic [7:0] a; // Frame number, offset_0 or frames_back
		logic [7:0] b; // N or an offset
		logic [7:0] c; // Read offset_1
		bbox_t box_0; // Written or expected boxes
		bbox_t box_1;
		logic err;
	} case_t;

	logic clk, reset_N;
	logic frame_valid, frame_ready, wr_valid, wr_ready, wr_drop;
	logic rd_valid, rd_ready, rsp_valid, rsp_ready;
	frame_cfg_t frame;
	wr_req_t wr;
	rd_req_t rd;
	rd_rsp_t rsp;

	case_t cases [MAX_CASES];
	rd_rsp_t exp_q [$]; // Expected responses in request order
	integer seed = 20529;
	logic [31:0] rand_word;
	int num_cases = 0;
	int rsp_seen = 0;
	int cycle_count = 0;
	int timeout_limit = 200; // Recomputed once the cases are loaded
	int cur_n = 1; // Region count of the last frame

	oflow_top dut_i (
		.clk(clk), .reset_N(reset_N),
		.frame_valid(frame_valid), .frame_ready(frame_ready), .frame(frame),
		.wr_valid(wr_valid), .wr_ready(wr_ready), .wr(wr), .wr_drop(wr_drop),
		.rd_valid(rd_valid), .rd_ready(rd_ready), .rd(rd),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("ERR t=%0t %s got %0h expected %0h", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "Run aborted");
	endtask

	task automatic load_cases();
		int fd;
		int code;
		int need;
		int ch;
		byte kind;
		int v_a, v_b, v_c, v_err;
		logic [31:0] v_box0, v_box1;
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			abort_run({"Cannot open the case file ", CASE_FILE});
		end else begin
			while ($fscanf(fd, " %c", kind) == 1) begin
				v_a = 0;
				v_b = 0;
				v_c = 0;
				v_err = 0;
				v_box0 = '0;
				v_box1 = '0;
				case (kind)
					"#": begin // Comment runs to the end of the line
						ch = 0;
						while (ch != "\n" && ch != -1)
							ch = $fgetc(fd);
						need = 0;
						code = 0;
					end
					"F": begin
						need = 2;
						code = $fscanf(fd, "%d %d", v_a, v_b);
					end
					"W": begin
						need = 4;
						code = $fscanf(fd, "%d %d %h %h", v_a, v_b, v_box0, v_box1);
					end
					"R": begin
						need = 6;
						code = $fscanf(fd, "%d %d %d %h %h %d",
							v_a, v_b, v_c, v_box0, v_box1, v_err);
					end
					default: begin
						need = 1; // Unknown line type
						code = 0;
					end
				endcase
				if (code != need)
					abort_run($sformatf("Case file entry %0d is malformed", num_cases + 1));
				else if (kind != "#" && num_cases >= MAX_CASES)
					abort_run("The case file holds more entries than the testbench can store");
				else if (kind != "#") begin
					cases[num_cases] = '{kind: kind, a: v_a[7:0], b: v_b[7:0], c: v_c[7:0],
						box_0: bbox_t'(v_box0), box_1: bbox_t'(v_box1), err: v_err[0]};
					num_cases++;
				end
			end
			$fclose(fd);
		end
	endtask

	// Returns just after the edge that took the transfer
	task automatic wait_accept(input logic [7:0] kind);
		logic fired;
		fired = 1'b0;
		while (!fired) begin
			@(negedge clk);
			fired = (kind == "F") ? frame_ready : (kind == "W") ? wr_ready : rd_ready;
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	task automatic run_case(input case_t c);
		rd_rsp_t exp;
		int size;
		logic exp_drop;
		size = MEM_DEPTH / cur_n; // 128/N entries per region
		exp_drop = (int'(c.a) >= size) || (int'(c.b) >= size);
		if (c.kind == "F") begin
			frame = '{frame_num: c.a, num_hist: HIST_WIDTH'(c.b)};
			frame_valid = 1'b1;
		end else if (c.kind == "W") begin
			wr = '{offset_0: ADDR_WIDTH'(c.a), offset_1: ADDR_WIDTH'(c.b),
				bbox_0: c.box_0, bbox_1: c.box_1};
			wr_valid = 1'b1;
		end else begin
			rd = '{frames_back: HIST_WIDTH'(c.a), offset_0: ADDR_WIDTH'(c.b),
				offset_1: ADDR_WIDTH'(c.c)};
			rd_valid = 1'b1;
		end
		wait_accept(c.kind);
		{frame_valid, wr_valid, rd_valid} = 3'b000;
		if (c.kind == "F")
			cur_n = (c.b == 8'd0) ? 1 : (c.b > 8'(MAX_HISTORY)) ? MAX_HISTORY : int'(c.b);
		else if (c.kind == "W")
			check_val(64'(wr_drop), 64'(exp_drop), "wr_drop after write");
		else begin
			exp = '{bbox_0: c.box_0, bbox_1: c.box_1, err: c.err};
			exp_q.push_back(exp);
		end
	endtask

	task automatic take_response();
		rd_rsp_t exp;
		if (exp_q.size() == 0) begin
			check_val(64'd0, 64'd1, "response with no read outstanding");
		end else begin
			exp = exp_q.pop_front();
			rsp_seen++;
			check_val(64'(rsp.err), 64'(exp.err), $sformatf("response %0d err", rsp_seen));
			check_val(64'(rsp.bbox_0), 64'(exp.bbox_0), $sformatf("response %0d bbox_0", rsp_seen));
			check_val(64'(rsp.bbox_1), 64'(exp.bbox_1), $sformatf("response %0d bbox_1", rsp_seen));
		end
	endtask

	// Random rsp_ready, transfers taken at the negedge where all is stable
	always begin
		@(posedge clk);
		#DRIVE_DELAY;
		rand_word = $random(seed);
		rsp_ready = rand_word[0];
		@(negedge clk);
		if (reset_N && rsp_valid && rsp_ready)
			take_response();
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_limit)
			abort_run($sformatf("Timeout after %0d cycles, the DUT stopped handshaking",
				cycle_count));
	end

	initial begin
		clk = 1'b0;
		reset_N = 1'b0;
		{frame_valid, wr_valid, rd_valid, rsp_ready} = 4'b0000;
		frame = '0;
		wr = '0;
		rd = '0;
		load_cases();
		timeout_limit = 40 * num_cases + 200;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset_N = 1'b1;
		for (int k = 0; k < 6; k++) begin // Requests offered before any frame
			{wr_valid, rd_valid} = (k < 3) ? 2'b10 : 2'b01;
			@(negedge clk);
			check_val(64'({wr_ready, rd_ready, rsp_valid, wr_drop}), 64'd0,
				"ready or valid before the first frame");
			@(posedge clk);
			#DRIVE_DELAY;
		end
		{wr_valid, rd_valid} = 2'b00;
		for (int i = 0; i < num_cases; i++)
			run_case(cases[i]);
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		check_val(64'(rsp_valid), 64'd0, "rsp_valid after the last response");
		$display("Done: no errors");
		$finish;
	end

endmodule
